// ==== hdl/rx_dma.sv ====
// *************************************************
// receive DMA engine top. user packet stream in,
// upstream ring writes out, MI for configuration.
// *************************************************
`default_nettype none

module rx_dma #(
    parameter int  CHANNELS      = 4,
    parameter int  PKT_SIZE_MAX  = 64,
    parameter int  POINTER_WIDTH = 8,
    parameter int  CNTRS_WIDTH   = 16,
    localparam int CHAN_W        = (CHANNELS > 1) ? $clog2(CHANNELS) : 1,
    localparam int SIZE_W        = $clog2(PKT_SIZE_MAX + 1)
) (
    input  logic                              CLK,
    input  logic                              rst_n,
    // user stream.
    input  logic [rx_dma_pkg::DATA_WIDTH-1:0] rx_data,
    input  logic                              rx_sof,
    input  logic                              rx_eof,
    input  logic [CHAN_W-1:0]                 rx_chan,
    input  logic [SIZE_W-1:0]                 rx_pkt_size,
    input  logic [rx_dma_pkg::META_WIDTH-1:0] rx_meta,
    input  logic                              rx_valid,
    output logic                              rx_ready,
    // upstream.
    output logic [rx_dma_pkg::DATA_WIDTH-1:0] up_data,
    output logic                              up_sof,
    output logic                              up_eof,
    output logic                              up_valid,
    input  logic                              up_ready,
    // MI.
    input  logic [rx_dma_pkg::DATA_WIDTH-1:0] mi_addr,
    input  logic [rx_dma_pkg::DATA_WIDTH-1:0] mi_dwr,
    input  logic                              mi_wr,
    input  logic                              mi_rd,
    output logic [rx_dma_pkg::DATA_WIDTH-1:0] mi_drd,
    output logic                              mi_ardy,
    output logic                              mi_drdy
);
    logic rx_take;

    chan_ctrl_if #(.CHANNELS(CHANNELS), .POINTER_WIDTH(POINTER_WIDTH)) ctrl_if ();
    pkt_hdr_if hdr_if ();

    rx_dma_mi_regs #(
        .CHANNELS      (CHANNELS),
        .POINTER_WIDTH (POINTER_WIDTH),
        .CNTRS_WIDTH   (CNTRS_WIDTH)
    ) regs_u (
        .CLK     (CLK),
        .rst_n   (rst_n),
        .mi_addr (mi_addr),
        .mi_dwr  (mi_dwr),
        .mi_wr   (mi_wr),
        .mi_rd   (mi_rd),
        .mi_drd  (mi_drd),
        .mi_ardy (mi_ardy),
        .mi_drdy (mi_drdy),
        .ctrl    (ctrl_if.regs)
    );

    rx_dma_hdr_gen #(
        .CHANNELS      (CHANNELS),
        .PKT_SIZE_MAX  (PKT_SIZE_MAX),
        .POINTER_WIDTH (POINTER_WIDTH)
    ) hdr_gen_u (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .rx_sof      (rx_sof),
        .rx_chan     (rx_chan),
        .rx_pkt_size (rx_pkt_size),
        .rx_meta     (rx_meta),
        .rx_take     (rx_take),
        .ctrl        (ctrl_if.gen),
        .hdr         (hdr_if.src)
    );

    rx_dma_transfer transfer_u (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .rx_data  (rx_data),
        .rx_sof   (rx_sof),
        .rx_eof   (rx_eof),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .rx_take  (rx_take),
        .hdr      (hdr_if.dst),
        .up_data  (up_data),
        .up_sof   (up_sof),
        .up_eof   (up_eof),
        .up_valid (up_valid),
        .up_ready (up_ready)
    );

endmodule

`default_nettype wire

// ==== hdl/rx_dma_hdr_gen.sv ====
// *************************************************
// builds the upstream transaction header from the
// start-of-packet metadata, or marks the packet dropped.
// *************************************************
`default_nettype none

module rx_dma_hdr_gen #(
    parameter int  CHANNELS      = 4,
    parameter int  PKT_SIZE_MAX  = 64,
    parameter int  POINTER_WIDTH = 8,
    localparam int CHAN_W        = (CHANNELS > 1) ? $clog2(CHANNELS) : 1,
    localparam int SIZE_W        = $clog2(PKT_SIZE_MAX + 1)
) (
    input  logic                              CLK,
    input  logic                              rst_n,
    input  logic                              rx_sof,
    input  logic [CHAN_W-1:0]                 rx_chan,
    input  logic [SIZE_W-1:0]                 rx_pkt_size,
    input  logic [rx_dma_pkg::META_WIDTH-1:0] rx_meta,
    input  logic                              rx_take,
    chan_ctrl_if.gen                          ctrl,
    pkt_hdr_if.src                            hdr
);
    localparam int DW          = rx_dma_pkg::DATA_WIDTH;
    localparam int INFO_SIZE_W = DW - rx_dma_pkg::META_WIDTH;

    rx_dma_pkg::hdr_state_t   state;
    logic [CHAN_W-1:0]        chan_q;
    logic [DW-1:0]            addr_q;
    logic [DW-1:0]            info_q;
    logic                     drop_q;
    logic [POINTER_WIDTH-1:0] new_ptr_q;

    logic [DW-1:0]            ptr_ext;
    logic [POINTER_WIDTH-1:0] size_bytes;
    logic [INFO_SIZE_W-1:0]   size_field;

    // look up the arriving channel, then stay on the held one until the update.
    assign ctrl.chan = (state == rx_dma_pkg::HOLD) ? chan_q : rx_chan;

    assign ptr_ext    = {{(DW-POINTER_WIDTH){1'b0}}, ctrl.ptr};
    assign size_bytes = POINTER_WIDTH'({rx_pkt_size, 2'b00}); // words to bytes, ring wrap.
    assign size_field = INFO_SIZE_W'(rx_pkt_size);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state <= rx_dma_pkg::IDLE;
        end else begin
            case (state)
                rx_dma_pkg::IDLE: if (rx_take) state <= rx_dma_pkg::HOLD;
                rx_dma_pkg::HOLD: if (hdr.ready) state <= rx_dma_pkg::IDLE;
            endcase
        end
    end

    // header fields, captured with the sof word.
    always_ff @(posedge CLK) begin
        if (state == rx_dma_pkg::IDLE && rx_take) begin
            chan_q    <= rx_chan;
            addr_q    <= ctrl.base + ptr_ext;
            info_q    <= {rx_meta, size_field};
            drop_q    <= !ctrl.enable;
            new_ptr_q <= ctrl.ptr + size_bytes;
        end
    end

    assign hdr.valid = (state == rx_dma_pkg::HOLD);
    assign hdr.addr  = addr_q;
    assign hdr.info  = info_q;
    assign hdr.drop  = drop_q;

    // registers follow in the cycle the header leaves.
    assign ctrl.upd      = hdr.valid && hdr.ready;
    assign ctrl.upd_ptr  = new_ptr_q;
    assign ctrl.upd_drop = drop_q;

    // transfer block only takes sof words, and sizes stay in range.
    assert property (@(posedge CLK) disable iff (!rst_n)
        rx_take |-> rx_sof && rx_pkt_size != 0 && rx_pkt_size <= PKT_SIZE_MAX);

endmodule

`default_nettype wire

// ==== hdl/rx_dma_if.sv ====
// *************************************************
// internal links of the receive DMA engine: channel
// register lookup and the transaction header handoff.
// *************************************************
`default_nettype none

// header generator asks for one channel's settings and reports the new pointer.
interface chan_ctrl_if #(
    parameter int CHANNELS      = 4,
    parameter int POINTER_WIDTH = 8
);
    localparam int CHAN_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

    logic [CHAN_W-1:0]                 chan;
    logic                              enable;
    logic [rx_dma_pkg::DATA_WIDTH-1:0] base;
    logic [POINTER_WIDTH-1:0]          ptr;
    logic                              upd;      // one cycle per header taken.
    logic [POINTER_WIDTH-1:0]          upd_ptr;
    logic                              upd_drop; // count a drop instead.

    modport regs (input chan, upd, upd_ptr, upd_drop, output enable, base, ptr);
    modport gen  (output chan, upd, upd_ptr, upd_drop, input enable, base, ptr);
endinterface

// one header per packet, valid/ready.
interface pkt_hdr_if;
    logic                              valid;
    logic                              ready;
    logic [rx_dma_pkg::DATA_WIDTH-1:0] addr;
    logic [rx_dma_pkg::DATA_WIDTH-1:0] info; // {meta, size in words}.
    logic                              drop;

    modport src (output valid, addr, info, drop, input ready);
    modport dst (input valid, addr, info, drop, output ready);
endinterface

`default_nettype wire

// ==== hdl/rx_dma_mi_regs.sv ====
// *************************************************
// MI register bank. per-channel enable, base, write
// pointer and sent count, plus the global drop count.
// *************************************************
`default_nettype none

module rx_dma_mi_regs #(
    parameter int CHANNELS      = 4,
    parameter int POINTER_WIDTH = 8,
    parameter int CNTRS_WIDTH   = 16
) (
    input  logic                              CLK,
    input  logic                              rst_n,
    input  logic [rx_dma_pkg::DATA_WIDTH-1:0] mi_addr,
    input  logic [rx_dma_pkg::DATA_WIDTH-1:0] mi_dwr,
    input  logic                              mi_wr,
    input  logic                              mi_rd,
    output logic [rx_dma_pkg::DATA_WIDTH-1:0] mi_drd,
    output logic                              mi_ardy,
    output logic                              mi_drdy,
    chan_ctrl_if.regs                         ctrl
);
    localparam int DW     = rx_dma_pkg::DATA_WIDTH;
    localparam int CHAN_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;
    localparam logic [DW-1:0] WIN_END = CHANNELS * 16; // end of the channel windows.

    logic                     enable [CHANNELS];
    logic [DW-1:0]            base   [CHANNELS];
    logic [POINTER_WIDTH-1:0] ptr    [CHANNELS];
    logic [CNTRS_WIDTH-1:0]   sent   [CHANNELS];
    logic [CNTRS_WIDTH-1:0]   drop_cnt;

    logic                 ch_hit;
    logic [CHAN_W-1:0]    mi_chan;
    rx_dma_pkg::reg_sel_t sel;
    logic [DW-1:0]        rdata;

    assign ch_hit  = (mi_addr < WIN_END);
    assign mi_chan = mi_addr[4 +: CHAN_W];
    assign sel     = rx_dma_pkg::reg_sel_t'(mi_addr[3:2]);
    assign mi_ardy = rst_n; // every request accepted at once.

    // lookup for the header generator.
    assign ctrl.enable = enable[ctrl.chan];
    assign ctrl.base   = base[ctrl.chan];
    assign ctrl.ptr    = ptr[ctrl.chan];

    // *************************************************
    // register updates
    // *************************************************
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            for (int i = 0; i < CHANNELS; i++) begin
                enable[i] <= 1'b0;
                base[i]   <= '0;
                ptr[i]    <= '0;
                sent[i]   <= '0;
            end
            drop_cnt <= '0;
        end else begin
            if (mi_wr && ch_hit) begin
                case (sel)
                    rx_dma_pkg::REG_CTRL: enable[mi_chan] <= mi_dwr[0];
                    rx_dma_pkg::REG_BASE: base[mi_chan]   <= mi_dwr;
                    default: ; // pointer and counter are read only.
                endcase
            end
            // engine side never touches enable or base.
            if (ctrl.upd) begin
                if (ctrl.upd_drop) begin
                    drop_cnt <= drop_cnt + 1'b1;
                end else begin
                    ptr[ctrl.chan]  <= ctrl.upd_ptr;
                    sent[ctrl.chan] <= sent[ctrl.chan] + 1'b1;
                end
            end
        end
    end

    // read mux, unmapped space reads zero.
    always_comb begin
        rdata = '0;
        if (ch_hit) begin
            case (sel)
                rx_dma_pkg::REG_CTRL: rdata = {{(DW-1){1'b0}}, enable[mi_chan]};
                rx_dma_pkg::REG_BASE: rdata = base[mi_chan];
                rx_dma_pkg::REG_PTR:  rdata = {{(DW-POINTER_WIDTH){1'b0}}, ptr[mi_chan]};
                rx_dma_pkg::REG_SENT: rdata = {{(DW-CNTRS_WIDTH){1'b0}}, sent[mi_chan]};
            endcase
        end else if (mi_addr == rx_dma_pkg::DROP_ADDR) begin
            rdata = {{(DW-CNTRS_WIDTH){1'b0}}, drop_cnt};
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            mi_drdy <= 1'b0;
        end else begin
            mi_drdy <= mi_rd; // one cycle read latency.
        end
        mi_drd <= rdata;
    end

    assert property (@(posedge CLK) disable iff (!rst_n) !(mi_wr && mi_rd));

endmodule

`default_nettype wire

// ==== hdl/rx_dma_pkg.sv ====
// *************************************************
// widths, MI register map and state encodings shared
// by the receive DMA engine blocks.
// *************************************************
`default_nettype none

package rx_dma_pkg;

    localparam int DATA_WIDTH = 32; // stream and MI word.
    localparam int META_WIDTH = 24; // user header metadata.

    // *************************************************
    // MI register map
    // *************************************************
    // each channel owns a 16-byte window, register picked by address bits [3:2].
    typedef enum logic [1:0] {
        REG_CTRL = 2'b00, // 0x0, bit 0 enables the channel.
        REG_BASE = 2'b01, // 0x4, ring base address.
        REG_PTR  = 2'b10, // 0x8, hardware write pointer, read only.
        REG_SENT = 2'b11  // 0xc, sent packet count, read only.
    } reg_sel_t;

    // global drop counter, just above the largest channel block.
    localparam logic [DATA_WIDTH-1:0] DROP_ADDR = 32'h0000_0080;

    // *************************************************
    // state encodings
    // *************************************************
    typedef enum logic {
        IDLE, // waiting for a start of packet.
        HOLD  // header registered, waiting to be taken.
    } hdr_state_t;

    typedef enum logic [1:0] {
        HDR_ADDR, // target address word.
        HDR_INFO, // metadata and size word.
        DATA,     // packet payload.
        DISCARD   // payload of a dropped packet.
    } xfer_state_t;

endpackage

`default_nettype wire

// ==== hdl/rx_dma_transfer.sv ====
// *************************************************
// frames the upstream write: address word, info word,
// then the payload. dropped packets are swallowed.
// *************************************************
`default_nettype none

module rx_dma_transfer (
    input  logic                              CLK,
    input  logic                              rst_n,
    input  logic [rx_dma_pkg::DATA_WIDTH-1:0] rx_data,
    input  logic                              rx_sof,
    input  logic                              rx_eof,
    input  logic                              rx_valid,
    output logic                              rx_ready,
    output logic                              rx_take,
    pkt_hdr_if.dst                            hdr,
    output logic [rx_dma_pkg::DATA_WIDTH-1:0] up_data,
    output logic                              up_sof,
    output logic                              up_eof,
    output logic                              up_valid,
    input  logic                              up_ready
);
    localparam int DW = rx_dma_pkg::DATA_WIDTH;

    rx_dma_pkg::xfer_state_t state;

    // one word of input buffering.
    logic [DW-1:0] hold_data;
    logic          hold_valid;
    logic          hold_eof;

    logic          out_free;
    logic          drain;
    logic          load;
    logic [DW-1:0] load_data;
    logic          load_sof;
    logic          load_eof;

    assign out_free = !up_valid || up_ready;
    assign drain    = hold_valid && ((state == rx_dma_pkg::DATA && out_free) ||
                                     state == rx_dma_pkg::DISCARD);
    assign rx_ready = !hold_valid || drain;
    assign rx_take  = rx_valid && rx_ready && rx_sof; // metadata goes to the header generator.

    // drops leave from the address state, sends after the info word.
    assign hdr.ready = (state == rx_dma_pkg::HDR_ADDR && hdr.valid && hdr.drop) ||
                       (state == rx_dma_pkg::HDR_INFO && out_free);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (rx_valid && rx_ready) begin
            hold_valid <= 1'b1;
        end else if (drain) begin
            hold_valid <= 1'b0;
        end
        if (rx_valid && rx_ready) begin
            hold_data <= rx_data;
            hold_eof  <= rx_eof;
        end
    end

    // *************************************************
    // output word selection
    // *************************************************
    always_comb begin
        load      = 1'b0;
        load_data = hold_data;
        load_sof  = 1'b0;
        load_eof  = 1'b0;
        case (state)
            rx_dma_pkg::HDR_ADDR: begin
                load      = hdr.valid && !hdr.drop;
                load_data = hdr.addr;
                load_sof  = 1'b1;
            end
            rx_dma_pkg::HDR_INFO: begin
                load      = 1'b1;
                load_data = hdr.info;
            end
            rx_dma_pkg::DATA: begin
                load     = hold_valid;
                load_eof = hold_eof;
            end
            default: ; // nothing goes upstream.
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state <= rx_dma_pkg::HDR_ADDR;
        end else begin
            case (state)
                rx_dma_pkg::HDR_ADDR: begin
                    if (hdr.valid && hdr.drop) state <= rx_dma_pkg::DISCARD;
                    else if (load && out_free) state <= rx_dma_pkg::HDR_INFO;
                end
                rx_dma_pkg::HDR_INFO: if (out_free) state <= rx_dma_pkg::DATA;
                default: if (drain && hold_eof) state <= rx_dma_pkg::HDR_ADDR;
            endcase
        end
    end

    // output register, held while upstream stalls.
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            up_valid <= 1'b0;
            up_sof   <= 1'b0;
            up_eof   <= 1'b0;
        end else if (out_free) begin
            up_valid <= load;
            up_sof   <= load && load_sof;
            up_eof   <= load && load_eof;
        end
        if (out_free && load) begin
            up_data <= load_data;
        end
    end

    assert property (@(posedge CLK) disable iff (!rst_n)
        up_valid && !up_ready |=> up_valid && $stable(up_data));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the receive DMA testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module rx_dma_tb \
    -f rx_dma.f -o rx_dma_sim \
    && ./obj_dir/rx_dma_sim | tee /dev/stderr | grep -q "TEST PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== rx_dma.f ====
hdl/rx_dma_pkg.sv
hdl/rx_dma_if.sv
hdl/rx_dma_mi_regs.sv
hdl/rx_dma_hdr_gen.sv
hdl/rx_dma_transfer.sv
hdl/rx_dma.sv
tests/rx_dma_tb.sv

// ==== tests/rx_dma_tb.sv ====
// *************************************************
// testbench for the receive DMA engine. applies a table of MI
// accesses and packets and checks upstream words against a model.
// *************************************************
`default_nettype none

module rx_dma_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int K_WR  = 0;
    localparam int K_RD  = 1;
    localparam int K_PKT = 2;

    logic        CLK;
    logic        rst_n;
    logic [31:0] rx_data;
    logic        rx_sof;
    logic        rx_eof;
    logic [1:0]  rx_chan;
    logic [6:0]  rx_pkt_size;
    logic [23:0] rx_meta;
    logic        rx_valid;
    logic        rx_ready;
    logic [31:0] up_data;
    logic        up_sof;
    logic        up_eof;
    logic        up_valid;
    logic        up_ready;
    logic [31:0] mi_addr;
    logic [31:0] mi_dwr;
    logic        mi_wr;
    logic        mi_rd;
    logic [31:0] mi_drd;
    logic        mi_ardy;
    logic        mi_drdy;

    // stimulus table with one column per field.
    int          kind_q[$];
    logic [31:0] a_q[$];     // MI address or channel.
    logic [31:0] b_q[$];     // MI data or size.
    logic [31:0] c_q[$];     // packet metadata.
    logic [31:0] d_q[$];     // first data word.

    // reference model.
    logic        m_en   [4];
    logic [31:0] m_base [4];
    logic [7:0]  m_ptr  [4];
    logic [15:0] m_sent [4];
    logic [15:0] m_drop;
    logic [33:0] exp_q[$];   // {sof, eof, data}.

    int     errors = 0;
    int     checks = 0;
    int     total_words = 0;
    int     limit = 0;
    int     cycles = 0;
    integer seed = 32'h3c050b9d;

    rx_dma DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic add_entry(input int kind, input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] c, input logic [31:0] d);
        kind_q.push_back(kind);
        a_q.push_back(a);
        b_q.push_back(b);
        c_q.push_back(c);
        d_q.push_back(d);
        total_words += (kind == K_PKT) ? int'(b) + 2 : 1;
    endtask

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        logic [1:0] ch;
        ch = addr[5:4];
        if (addr < 32'h40) begin
            case (addr[3:2])
                2'd0:    return {31'd0, m_en[ch]};
                2'd1:    return m_base[ch];
                2'd2:    return {24'd0, m_ptr[ch]};
                default: return {16'd0, m_sent[ch]};
            endcase
        end
        return (addr == 32'h80) ? {16'd0, m_drop} : 32'd0;
    endfunction

    // queue the upstream words a packet should produce.
    task automatic model_packet(input int ch, input int size, input logic [23:0] meta,
                                input logic [31:0] d0);
        if (!m_en[ch]) begin
            m_drop++;
            return;
        end
        exp_q.push_back({2'b10, m_base[ch] + {24'd0, m_ptr[ch]}});
        exp_q.push_back({2'b00, meta, 8'(size)});
        for (int i = 0; i < size; i++) begin
            exp_q.push_back({1'b0, i == size - 1, d0 + 32'(i)});
        end
        m_ptr[ch] = m_ptr[ch] + 8'(4 * size); // ring wraps at 256 bytes.
        m_sent[ch]++;
    endtask

    task automatic send_packet(input int ch, input int size, input logic [23:0] meta,
                               input logic [31:0] d0);
        for (int i = 0; i < size; i++) begin
            @(negedge CLK);
            rx_valid    = 1'b1;
            rx_data     = d0 + 32'(i);
            rx_sof      = (i == 0);
            rx_eof      = (i == size - 1);
            rx_chan     = (i == 0) ? 2'(ch) : 2'd0;
            rx_pkt_size = (i == 0) ? 7'(size) : 7'd0;
            rx_meta     = (i == 0) ? meta : 24'd0;
            #1;
            while (!rx_ready) begin
                @(negedge CLK);
                #1;
            end
        end
    endtask

    // let in-flight packets finish before touching registers.
    task automatic settle();
        @(negedge CLK);
        rx_valid = 1'b0;
        rx_sof   = 1'b0;
        rx_eof   = 1'b0;
        while (exp_q.size() != 0) @(negedge CLK);
        repeat (4) @(negedge CLK);
    endtask

    task automatic mi_access(input bit wr, input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] exp;
        @(negedge CLK);
        mi_addr = addr;
        mi_dwr  = data;
        mi_wr   = wr;
        mi_rd   = !wr;
        #1;
        check("mi_ardy", {31'd0, mi_ardy}, 32'd1);
        exp = model_read(addr);
        @(negedge CLK);
        mi_wr = 1'b0;
        mi_rd = 1'b0;
        if (wr) begin
            check("mi_drdy", {31'd0, mi_drdy}, 32'd0);
            if (addr < 32'h40 && addr[3:2] == 2'd0) m_en[addr[5:4]] = data[0];
            if (addr < 32'h40 && addr[3:2] == 2'd1) m_base[addr[5:4]] = data;
        end else begin
            check("mi_drdy", {31'd0, mi_drdy}, 32'd1);
            check("mi_drd", mi_drd, exp);
        end
    endtask

    // *************************************************
    // upstream sink with random back-pressure
    // *************************************************
    initial begin
        logic [33:0] w;
        up_ready = 1'b0;
        wait (rst_n);
        forever begin
            @(negedge CLK);
            up_ready = ($random(seed) & 32'h3) != 0;
            #1;
            if (up_valid && up_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("error: upstream word %h arrived with nothing expected", up_data);
                end else begin
                    w = exp_q.pop_front();
                    check("up_data", up_data, w[31:0]);
                    check("up_sof", {31'd0, up_sof}, {31'd0, w[33]});
                    check("up_eof", {31'd0, up_eof}, {31'd0, w[32]});
                end
            end
        end
    end

    initial begin
        wait (limit > 0);
        while (cycles <= limit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        bit after_pkt;
        rst_n = 1'b0;
        {rx_data, rx_sof, rx_eof, rx_chan, rx_pkt_size, rx_meta, rx_valid} = '0;
        {mi_addr, mi_dwr, mi_wr, mi_rd} = '0;
        for (int ch = 0; ch < 4; ch++) begin
            m_en[ch]   = 1'b0;
            m_base[ch] = '0;
            m_ptr[ch]  = '0;
            m_sent[ch] = '0;
        end
        m_drop = '0;

        // register access after reset and then channel setup. ch2 stays disabled.
        add_entry(K_RD, 32'h08, 0, 0, 0);
        add_entry(K_RD, 32'h0c, 0, 0, 0);
        add_entry(K_RD, 32'h80, 0, 0, 0);
        add_entry(K_WR, 32'h00, 32'h1, 0, 0);
        add_entry(K_WR, 32'h04, 32'h1000_0000, 0, 0);
        add_entry(K_RD, 32'h00, 0, 0, 0);
        add_entry(K_RD, 32'h04, 0, 0, 0);
        add_entry(K_WR, 32'h08, 32'h44, 0, 0); // read only so the write must not stick.
        add_entry(K_RD, 32'h08, 0, 0, 0);
        add_entry(K_WR, 32'h10, 32'hffff_ffff, 0, 0);
        add_entry(K_WR, 32'h14, 32'h2000_0000, 0, 0);
        add_entry(K_WR, 32'h24, 32'h3000_0000, 0, 0);
        add_entry(K_WR, 32'h30, 32'h1, 0, 0);
        add_entry(K_WR, 32'h34, 32'h4000_0100, 0, 0);
        add_entry(K_RD, 32'h10, 0, 0, 0);
        add_entry(K_RD, 32'h24, 0, 0, 0);
        // single packet and a pointer walk past the ring end.
        add_entry(K_PKT, 0, 4, 32'habcdef, 32'h100);
        add_entry(K_PKT, 0, 16, 32'h000011, 32'h200);
        add_entry(K_RD, 32'h08, 0, 0, 0);
        add_entry(K_PKT, 0, 30, 32'h000022, 32'h300);
        add_entry(K_PKT, 0, 20, 32'h000033, 32'h400);
        add_entry(K_RD, 32'h08, 0, 0, 0);
        // drops on the disabled channel.
        add_entry(K_PKT, 2, 5, 32'h5a5a5a, 32'h500);
        add_entry(K_PKT, 2, 1, 32'h5b5b5b, 32'h600);
        add_entry(K_RD, 32'h80, 0, 0, 0);
        add_entry(K_RD, 32'h28, 0, 0, 0);
        // back to back on mixed channels.
        add_entry(K_PKT, 1, 3, 32'h100001, 32'h1000);
        add_entry(K_PKT, 3, 1, 32'h300001, 32'h2000);
        add_entry(K_PKT, 0, 8, 32'h000044, 32'h3000);
        add_entry(K_PKT, 2, 2, 32'h200001, 32'h4000);
        add_entry(K_PKT, 1, 64, 32'h100002, 32'h5000);
        add_entry(K_PKT, 3, 10, 32'h300002, 32'h6000);
        add_entry(K_PKT, 0, 1, 32'h000055, 32'h7000);
        // final counters and pointers plus one unmapped address.
        add_entry(K_RD, 32'h0c, 0, 0, 0);
        add_entry(K_RD, 32'h1c, 0, 0, 0);
        add_entry(K_RD, 32'h2c, 0, 0, 0);
        add_entry(K_RD, 32'h3c, 0, 0, 0);
        add_entry(K_RD, 32'h80, 0, 0, 0);
        add_entry(K_RD, 32'h18, 0, 0, 0);
        add_entry(K_RD, 32'h38, 0, 0, 0);
        add_entry(K_RD, 32'h84, 0, 0, 0);
        limit = 20 * total_words + 200;

        repeat (3) @(negedge CLK);
        rst_n = 1'b1;

        after_pkt = 1'b0;
        for (int n = 0; n < kind_q.size(); n++) begin
            if (kind_q[n] == K_PKT) begin
                model_packet(int'(a_q[n]), int'(b_q[n]), c_q[n][23:0], d_q[n]);
                send_packet(int'(a_q[n]), int'(b_q[n]), c_q[n][23:0], d_q[n]);
                after_pkt = 1'b1;
                $display("test %0d: packet ch %0d size %0d accepted, errors %0d",
                         n, a_q[n], b_q[n], errors);
            end else begin
                if (after_pkt) settle();
                after_pkt = 1'b0;
                mi_access(kind_q[n] == K_WR, a_q[n], b_q[n]);
                $display("test %0d: mi %s addr %h done, errors %0d",
                         n, (kind_q[n] == K_WR) ? "write" : "read", a_q[n], errors);
            end
        end
        settle();

        $display("finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
